// ==== hw/fpDivPkg.sv ====
`default_nettype none

package fpDivPkg;

	// ----------------------------------------
	// field widths and constants
	// ----------------------------------------
	localparam int EXP_W = 11;
	localparam int FRAC_W = 52;
	localparam int EXP_BIAS = 1023;
	// 53 mantissa bits plus guard, round and a spare for the normalize shift
	localparam int QUOT_W = 56;
	localparam int TAG_W = 4;
	// entries in the request queue and credits held by the requester
	localparam int QUEUE_DEPTH = 2;
	// canonical quiet NaN has only the top fraction bit set
	localparam logic [FRAC_W-1:0] QNAN_FRAC = {1'b1, {(FRAC_W-1){1'b0}}};

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exp;
		logic [FRAC_W-1:0] frac;
	} fp64T;

	typedef enum logic [1:0] {CLS_ZERO, CLS_NORMAL, CLS_INF, CLS_NAN} fpClassT;

	// operand after the split, mantissa carries the hidden bit
	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exp;
		logic [FRAC_W:0] mant;
		fpClassT cls;
	} unpackT;

	typedef enum logic [1:0] {SPEC_NONE, SPEC_ZERO, SPEC_INF, SPEC_NAN} specialT;

	typedef enum logic [1:0] {ST_IDLE, ST_DECODE, ST_DIVIDE, ST_PACK} coreStateT;

	typedef struct packed {
		logic invalid;
		logic divideByZero;
		logic overflow;
		logic underflow;
	} fpFlagsT;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		fp64T a;
		fp64T b;
	} divReqT;

	// core result before rounding, sticky already folded into quot lsb
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic sign;
		logic signed [EXP_W+1:0] exp;
		logic [QUOT_W-1:0] quot;
		specialT kind;
		logic [FRAC_W-1:0] nanFrac;
		logic invalid;
		logic divideByZero;
	} extResT;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		fp64T value;
		fpFlagsT flags;
	} divResT;

endpackage

`default_nettype wire

// ==== hw/fpDecompose.sv ====
`timescale 1ns/100ps
`default_nettype none

module fpDecompose (
	input wire logic clk,
	input wire fpDivPkg::fp64T x,
	output fpDivPkg::unpackT u
);

	// exponent field patterns
	logic expZero;
	logic expOnes;
	logic fracZero;

	assign expZero = (x.exp == '0);
	assign expOnes = &x.exp;
	assign fracZero = (x.frac == '0);

	// one register stage for the whole split
	always_ff @(posedge clk) begin
		u.sign <= x.sign;
		u.exp <= x.exp;
		if (expZero) begin
			// subnormals are read as signed zero
			u.cls <= fpDivPkg::CLS_ZERO;
			u.mant <= '0;
		end else if (expOnes) begin
			u.cls <= fracZero ? fpDivPkg::CLS_INF : fpDivPkg::CLS_NAN;
			// hidden bit stays clear, the fraction is kept as NaN payload
			u.mant <= {1'b0, x.frac};
		end else begin
			u.cls <= fpDivPkg::CLS_NORMAL;
			u.mant <= {1'b1, x.frac};
		end
	end

endmodule

`default_nettype wire

// ==== hw/mantDivider.sv ====
`timescale 1ns/100ps
`default_nettype none

module mantDivider (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic [52:0] dividend,
	input wire logic [52:0] divisor,
	output logic quotValid,
	output logic [fpDivPkg::QUOT_W-1:0] quotient,
	output logic sticky
);

	// partial remainder, one bit wider than the mantissa
	logic [53:0] rem;
	// divisor held for the whole run
	logic [52:0] divHeld;
	logic [$clog2(fpDivPkg::QUOT_W)-1:0] bitCnt;
	logic busy;

	// one restoring step, shared by the start cycle and the run
	logic [53:0] stepIn;
	logic [53:0] divSel;
	logic [53:0] diff;
	logic [53:0] stepOut;
	logic qBit;

	// ----------------------------------------
	// compare and subtract
	// ----------------------------------------
	always_comb begin
		// first bit comes straight from the operands
		stepIn = start ? {1'b0, dividend} : rem;
		divSel = start ? {1'b0, divisor} : {1'b0, divHeld};
		diff = stepIn - divSel;
		qBit = (stepIn >= divSel);
		// restore when the subtract would go negative
		stepOut = qBit ? diff : stepIn;
	end

	// ----------------------------------------
	// bit counter and control
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			bitCnt <= '0;
			quotValid <= 1'b0;
		end else begin
			quotValid <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				bitCnt <= 1;
			end else if (busy) begin
				bitCnt <= bitCnt + 1'b1;
				// last quotient bit lands on this edge
				if (int'(bitCnt) == fpDivPkg::QUOT_W - 1) begin
					busy <= 1'b0;
					quotValid <= 1'b1;
				end
			end
		end
	end

	// datapath registers
	always_ff @(posedge clk) begin
		if (start) begin
			divHeld <= divisor;
			// msb of the quotient is the integer bit
			quotient <= {{(fpDivPkg::QUOT_W-1){1'b0}}, qBit};
			rem <= {stepOut[52:0], 1'b0};
		end else if (busy) begin
			quotient <= {quotient[fpDivPkg::QUOT_W-2:0], qBit};
			// remainder is below the divisor so the top bit drops safely
			rem <= {stepOut[52:0], 1'b0};
		end
	end

	// any leftover remainder means the quotient is inexact
	assign sticky = |rem;

endmodule

`default_nettype wire

// ==== hw/fpDivCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module fpDivCore (
	input wire logic clk,
	input wire logic rst,
	input wire logic headValid,
	input wire fpDivPkg::divReqT head,
	output logic take,
	output logic extValid,
	output fpDivPkg::extResT ext
);

	fpDivPkg::coreStateT state;
	fpDivPkg::unpackT decA;
	fpDivPkg::unpackT decB;
	fpDivPkg::extResT extR;

	// mantissas held for the divider
	logic [52:0] mantA;
	logic [52:0] mantB;

	// divider handshake
	logic startR;
	logic quotValid;
	logic [fpDivPkg::QUOT_W-1:0] quotient;
	logic sticky;

	// decode results, valid during ST_DECODE
	fpDivPkg::specialT kind;
	logic [fpDivPkg::FRAC_W-1:0] nanFrac;
	logic resSign;
	logic invalid;
	logic divZero;
	logic signed [fpDivPkg::EXP_W+1:0] expDiff;

	// operands are split on the take edge
	fpDecompose decompA (.clk(clk), .x(head.a), .u(decA));
	fpDecompose decompB (.clk(clk), .x(head.b), .u(decB));

	mantDivider divider (
		.clk(clk),
		.rst(rst),
		.start(startR),
		.dividend(mantA),
		.divisor(mantB),
		.quotValid(quotValid),
		.quotient(quotient),
		.sticky(sticky)
	);

	// pop the queue head as soon as the core is free
	assign take = headValid && (state == fpDivPkg::ST_IDLE);
	assign extValid = (state == fpDivPkg::ST_PACK);
	assign ext = extR;

	// biased exponent of the raw quotient
	assign expDiff = (fpDivPkg::EXP_W+2)'($signed({2'b00, decA.exp})
		- $signed({2'b00, decB.exp}) + fpDivPkg::EXP_BIAS);

	// ----------------------------------------
	// special operand classification
	// ----------------------------------------
	always_comb begin
		kind = fpDivPkg::SPEC_NONE;
		nanFrac = fpDivPkg::QNAN_FRAC;
		resSign = decA.sign ^ decB.sign;
		invalid = 1'b0;
		divZero = 1'b0;
		if (decA.cls == fpDivPkg::CLS_NAN) begin
			// quiet the payload of a
			kind = fpDivPkg::SPEC_NAN;
			nanFrac = decA.mant[fpDivPkg::FRAC_W-1:0] | fpDivPkg::QNAN_FRAC;
			resSign = decA.sign;
		end else if (decB.cls == fpDivPkg::CLS_NAN) begin
			kind = fpDivPkg::SPEC_NAN;
			nanFrac = decB.mant[fpDivPkg::FRAC_W-1:0] | fpDivPkg::QNAN_FRAC;
			resSign = decB.sign;
		end else if ((decA.cls == decB.cls) && (decA.cls inside {fpDivPkg::CLS_ZERO,
				fpDivPkg::CLS_INF})) begin
			// 0/0 and inf/inf
			kind = fpDivPkg::SPEC_NAN;
			resSign = 1'b0;
			invalid = 1'b1;
		end else if (decA.cls == fpDivPkg::CLS_INF) begin
			kind = fpDivPkg::SPEC_INF;
		end else if (decB.cls == fpDivPkg::CLS_ZERO) begin
			// finite nonzero over zero
			kind = fpDivPkg::SPEC_INF;
			divZero = 1'b1;
		end else if (decB.cls == fpDivPkg::CLS_INF || decA.cls == fpDivPkg::CLS_ZERO) begin
			kind = fpDivPkg::SPEC_ZERO;
		end
	end

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fpDivPkg::ST_IDLE;
			startR <= 1'b0;
		end else begin
			startR <= 1'b0;
			case (state)
				fpDivPkg::ST_IDLE: begin
					if (take) begin
						state <= fpDivPkg::ST_DECODE;
					end
				end
				fpDivPkg::ST_DECODE: begin
					// special results skip the divider
					if (kind == fpDivPkg::SPEC_NONE) begin
						state <= fpDivPkg::ST_DIVIDE;
						startR <= 1'b1;
					end else begin
						state <= fpDivPkg::ST_PACK;
					end
				end
				fpDivPkg::ST_DIVIDE: begin
					if (quotValid) begin
						state <= fpDivPkg::ST_PACK;
					end
				end
				default: state <= fpDivPkg::ST_IDLE;
			endcase
		end
	end

	// result fields, loaded as they become known
	always_ff @(posedge clk) begin
		if (take) begin
			extR.tag <= head.tag;
		end
		if (state == fpDivPkg::ST_DECODE) begin
			mantA <= decA.mant;
			mantB <= decB.mant;
			extR.sign <= resSign;
			extR.exp <= expDiff;
			extR.quot <= '0;
			extR.kind <= kind;
			extR.nanFrac <= nanFrac;
			extR.invalid <= invalid;
			extR.divideByZero <= divZero;
		end
		// fold sticky into the lsb for rounding
		if (state == fpDivPkg::ST_DIVIDE && quotValid) begin
			extR.quot <= {quotient[fpDivPkg::QUOT_W-1:1], quotient[0] | sticky};
		end
	end

endmodule

`default_nettype wire

// ==== hw/fpNormRound.sv ====
`timescale 1ns/100ps
`default_nettype none

module fpNormRound (
	input wire logic clk,
	input wire logic rst,
	input wire logic extValid,
	input wire fpDivPkg::extResT ext,
	output logic resValid,
	output fpDivPkg::divResT res
);

	// stage 1 holds the normalized item
	fpDivPkg::extResT s1;
	logic v1;

	// stage 2 working values
	logic [fpDivPkg::FRAC_W:0] mant;
	logic guard;
	logic rest;
	logic roundUp;
	logic [fpDivPkg::FRAC_W+1:0] sum;
	logic [fpDivPkg::FRAC_W-1:0] fracR;
	logic signed [fpDivPkg::EXP_W+1:0] expR;
	fpDivPkg::divResT resNext;

	always_ff @(posedge clk) begin
		if (rst) begin
			v1 <= 1'b0;
			resValid <= 1'b0;
		end else begin
			v1 <= extValid;
			resValid <= v1;
		end
	end

	// ----------------------------------------
	// stage 1 normalize
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (extValid) begin
			s1 <= ext;
			// ratio below one so the first set bit moves up
			if (!ext.quot[fpDivPkg::QUOT_W-1]) begin
				s1.quot <= ext.quot << 1;
				s1.exp <= ext.exp - 1'b1;
			end
		end
	end

	// ----------------------------------------
	// stage 2 round and range check
	// ----------------------------------------
	always_comb begin
		mant = s1.quot[fpDivPkg::QUOT_W-1 -: fpDivPkg::FRAC_W+1];
		guard = s1.quot[fpDivPkg::QUOT_W-fpDivPkg::FRAC_W-2];
		// round bit and sticky only matter together
		rest = |s1.quot[fpDivPkg::QUOT_W-fpDivPkg::FRAC_W-3:0];
		// nearest even with ties going to an even lsb
		roundUp = guard & (rest | mant[0]);
		sum = {1'b0, mant} + {{(fpDivPkg::FRAC_W+1){1'b0}}, roundUp};
		expR = s1.exp;
		fracR = sum[fpDivPkg::FRAC_W-1:0];
		if (sum[fpDivPkg::FRAC_W+1]) begin
			// mantissa carried out to 2.0
			expR = s1.exp + 1'b1;
			fracR = sum[fpDivPkg::FRAC_W:1];
		end

		resNext.tag = s1.tag;
		resNext.value.sign = s1.sign;
		resNext.flags.invalid = s1.invalid;
		resNext.flags.divideByZero = s1.divideByZero;
		resNext.flags.overflow = 1'b0;
		resNext.flags.underflow = 1'b0;
		case (s1.kind)
			fpDivPkg::SPEC_ZERO: begin
				resNext.value.exp = '0;
				resNext.value.frac = '0;
			end
			fpDivPkg::SPEC_INF: begin
				resNext.value.exp = '1;
				resNext.value.frac = '0;
			end
			fpDivPkg::SPEC_NAN: begin
				resNext.value.exp = '1;
				resNext.value.frac = s1.nanFrac;
			end
			default: begin
				if (expR >= (2 ** fpDivPkg::EXP_W) - 1) begin
					// too large for the format so signed infinity
					resNext.value.exp = '1;
					resNext.value.frac = '0;
					resNext.flags.overflow = 1'b1;
				end else if (expR <= 0) begin
					// below normal range flushes to signed zero
					resNext.value.exp = '0;
					resNext.value.frac = '0;
					resNext.flags.underflow = 1'b1;
				end else begin
					resNext.value.exp = expR[fpDivPkg::EXP_W-1:0];
					resNext.value.frac = fracR;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (v1) begin
			res <= resNext;
		end
	end

endmodule

`default_nettype wire

// ==== hw/divReqQueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module divReqQueue (
	input wire logic clk,
	input wire logic rst,
	input wire logic reqValid,
	input wire fpDivPkg::divReqT req,
	input wire logic take,
	output logic headValid,
	output fpDivPkg::divReqT head,
	output logic creditReturn
);

	// circular buffer storage
	fpDivPkg::divReqT mem [fpDivPkg::QUEUE_DEPTH];
	logic [$clog2(fpDivPkg::QUEUE_DEPTH)-1:0] wrPtr;
	logic [$clog2(fpDivPkg::QUEUE_DEPTH)-1:0] rdPtr;
	logic [$clog2(fpDivPkg::QUEUE_DEPTH+1)-1:0] count;
	logic pop;

	assign headValid = (count != '0);
	assign head = mem[rdPtr];
	assign pop = take & headValid;
	// each entry leaving gives one credit back
	assign creditReturn = pop;

	// pointers wrap at the queue depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (reqValid) begin
				wrPtr <= (int'(wrPtr) == fpDivPkg::QUEUE_DEPTH - 1) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (int'(rdPtr) == fpDivPkg::QUEUE_DEPTH - 1) ? '0 : rdPtr + 1'b1;
			end
			case ({reqValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// credits keep the requester from writing a full queue
	always_ff @(posedge clk) begin
		if (reqValid) begin
			mem[wrPtr] <= req;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fpDivUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fpDivUnit (
	input wire logic clk,
	input wire logic rst,
	input wire logic reqValid,
	input wire fpDivPkg::divReqT req,
	output logic creditReturn,
	output logic resValid,
	output fpDivPkg::divResT res
);

	// queue to core
	logic headValid;
	fpDivPkg::divReqT head;
	logic take;

	// core to rounder
	logic extValid;
	fpDivPkg::extResT ext;

	// ----------------------------------------
	// request side
	// ----------------------------------------
	divReqQueue queue (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.req(req),
		.take(take),
		.headValid(headValid),
		.head(head),
		.creditReturn(creditReturn)
	);

	// one divide at a time keeps results in request order
	fpDivCore core (
		.clk(clk),
		.rst(rst),
		.headValid(headValid),
		.head(head),
		.take(take),
		.extValid(extValid),
		.ext(ext)
	);

	// ----------------------------------------
	// result side
	// ----------------------------------------
	fpNormRound normRound (
		.clk(clk),
		.rst(rst),
		.extValid(extValid),
		.ext(ext),
		.resValid(resValid),
		.res(res)
	);

endmodule

`default_nettype wire

// ==== sim/tbFpDivUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbFpDivUnit;

	logic clk;
	logic rst;
	logic reqValid;
	fpDivPkg::divReqT req;
	logic creditReturn;
	logic resValid;
	fpDivPkg::divResT res;

	// expected results in request order
	fpDivPkg::divResT sb[$];
	int sentCount;
	int reqSeen;
	int returnCount;
	logic [fpDivPkg::TAG_W-1:0] nextTag;
	logic [31:0] lfsr;

	fpDivUnit DUT (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.req(req),
		.creditReturn(creditReturn),
		.resValid(resValid),
		.res(res)
	);

	always #2 clk = ~clk;

	// ----------------------------------------
	// failure reporting and compare tasks
	// ----------------------------------------
	task stopRun(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	task checkResult(input fpDivPkg::divResT got, input fpDivPkg::divResT exp);
		if (got.tag !== exp.tag) begin
			stopRun($sformatf("[FAIL] %0t ns tag %0d arrived, expected tag %0d",
				$time, got.tag, exp.tag));
		end else if (got.value !== exp.value) begin
			stopRun($sformatf("[FAIL] %0t ns tag %0d value %h, expected %h",
				$time, got.tag, got.value, exp.value));
		end
	endtask

	task checkFlags(input fpDivPkg::fpFlagsT got, input fpDivPkg::fpFlagsT exp,
			input logic [fpDivPkg::TAG_W-1:0] tag);
		if (got !== exp) begin
			stopRun($sformatf("[FAIL] %0t ns tag %0d flags %b, expected %b",
				$time, tag, got, exp));
		end
	endtask

	// ----------------------------------------
	// random numbers
	// ----------------------------------------
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		// galois form of x^32 + x^22 + x^2 + x + 1
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end else begin
			return s >> 1;
		end
	endfunction

	// one lfsr step per bit taken
	task randBits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	// normal operand with exponent within 64 of the bias
	task randOperand(output fpDivPkg::fp64T x);
		logic [63:0] s;
		logic [63:0] e;
		logic [63:0] f;
		randBits(1, s);
		randBits(7, e);
		randBits(52, f);
		x.sign = s[0];
		x.exp = 11'(fpDivPkg::EXP_BIAS - 64 + int'(e[6:0]));
		x.frac = f[51:0];
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic fpDivPkg::fp64T fromReal(input real x);
		return fpDivPkg::fp64T'($realtobits(x));
	endfunction

	function automatic fpDivPkg::fp64T mkFp(input logic s, input logic [10:0] e,
			input logic [51:0] f);
		return {s, e, f};
	endfunction

	function automatic fpDivPkg::divResT refDivide(input fpDivPkg::divReqT r);
		fpDivPkg::divResT o;
		fpDivPkg::fp64T a;
		fpDivPkg::fp64T b;
		fpDivPkg::fp64T q;
		logic [63:0] aBits;
		logic [63:0] bBits;
		logic aZero;
		logic bZero;
		logic aInf;
		logic bInf;
		logic aNan;
		logic bNan;
		logic s;
		a = r.a;
		b = r.b;
		// subnormals count as signed zero
		if (a.exp == '0) a.frac = '0;
		if (b.exp == '0) b.frac = '0;
		aZero = (a.exp == '0);
		bZero = (b.exp == '0);
		aInf = (&a.exp) && (a.frac == '0);
		bInf = (&b.exp) && (b.frac == '0);
		aNan = (&a.exp) && (a.frac != '0);
		bNan = (&b.exp) && (b.frac != '0);
		s = a.sign ^ b.sign;
		o.tag = r.tag;
		o.flags = '0;
		if (aNan) begin
			o.value = {a.sign, 11'h7ff, a.frac | fpDivPkg::QNAN_FRAC};
		end else if (bNan) begin
			o.value = {b.sign, 11'h7ff, b.frac | fpDivPkg::QNAN_FRAC};
		end else if ((aZero && bZero) || (aInf && bInf)) begin
			o.value = {1'b0, 11'h7ff, fpDivPkg::QNAN_FRAC};
			o.flags.invalid = 1'b1;
		end else if (aInf) begin
			o.value = {s, 11'h7ff, 52'h0};
		end else if (bZero) begin
			o.value = {s, 11'h7ff, 52'h0};
			o.flags.divideByZero = 1'b1;
		end else if (bInf || aZero) begin
			o.value = {s, 11'h000, 52'h0};
		end else begin
			// host double division rounds to nearest even
			aBits = a;
			bBits = b;
			q = fpDivPkg::fp64T'($realtobits($bitstoreal(aBits) / $bitstoreal(bBits)));
			if (&q.exp) begin
				o.value = {s, 11'h7ff, 52'h0};
				o.flags.overflow = 1'b1;
			end else if (q.exp == '0) begin
				// no subnormal results, flush
				o.value = {s, 11'h000, 52'h0};
				o.flags.underflow = 1'b1;
			end else begin
				o.value = q;
			end
		end
		return o;
	endfunction

	// ----------------------------------------
	// request driver
	// ----------------------------------------
	task sendReq(input fpDivPkg::fp64T a, input fpDivPkg::fp64T b);
		fpDivPkg::divReqT r;
		// hold off on this edge until a credit is free
		while (fpDivPkg::QUEUE_DEPTH - sentCount + returnCount <= 0) begin
			reqValid <= 1'b0;
			@(posedge clk);
		end
		r.tag = nextTag;
		r.a = a;
		r.b = b;
		reqValid <= 1'b1;
		req <= r;
		sb.push_back(refDivide(r));
		sentCount++;
		nextTag = nextTag + 1'b1;
		@(posedge clk);
	endtask

	task drainResults();
		reqValid <= 1'b0;
		while (sb.size() != 0) begin
			@(posedge clk);
		end
	endtask

	// ----------------------------------------
	// monitor, samples mid cycle
	// ----------------------------------------
	always @(negedge clk) begin : monitor
		fpDivPkg::divResT expRes;
		if (!rst) begin
			if (reqValid) reqSeen++;
			if (creditReturn) returnCount++;
			if (returnCount > reqSeen) begin
				stopRun("a credit came back with no request outstanding");
			end
			if (reqSeen - returnCount > fpDivPkg::QUEUE_DEPTH) begin
				stopRun("a request went out without a credit");
			end
			if (resValid) begin
				if (sb.size() == 0) begin
					stopRun("a result arrived that no request was waiting for");
				end else begin
					expRes = sb.pop_front();
					checkResult(res, expRes);
					checkFlags(res.flags, expRes.flags, res.tag);
				end
			end
		end
	end

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task testExact();
		sendReq(fromReal(6.0), fromReal(3.0));
		sendReq(fromReal(1.0), fromReal(4.0));
		sendReq(fromReal(-9.0), fromReal(3.0));
		sendReq(fromReal(1.0), fromReal(1.0));
		// ratio below one needs the normalize shift
		sendReq(fromReal(2.0), fromReal(3.0));
		drainResults();
	endtask

	task testRandom();
		fpDivPkg::fp64T a;
		fpDivPkg::fp64T b;
		for (int i = 0; i < 64; i++) begin
			randOperand(a);
			randOperand(b);
			sendReq(a, b);
		end
		drainResults();
	endtask

	task testSpecial();
		// nan payloads from a, from b, and a winning over b
		sendReq(mkFp(1'b1, 11'h7ff, 52'h0_0000_0001_2345), fromReal(2.0));
		sendReq(fromReal(3.0), mkFp(1'b0, 11'h7ff, 52'h0_00ab_0000_0007));
		sendReq(mkFp(1'b0, 11'h7ff, 52'h1_0000_0000_0000),
			mkFp(1'b1, 11'h7ff, 52'h8_0000_0000_0001));
		sendReq(fromReal(0.0), fromReal(-0.0));
		sendReq(mkFp(1'b0, 11'h7ff, 52'h0), mkFp(1'b1, 11'h7ff, 52'h0));
		sendReq(fromReal(5.0), fromReal(0.0));
		sendReq(fromReal(-5.0), fromReal(0.0));
		sendReq(fromReal(5.0), mkFp(1'b0, 11'h7ff, 52'h0));
		sendReq(mkFp(1'b0, 11'h7ff, 52'h0), fromReal(-2.0));
		// signed zero results
		sendReq(fromReal(-0.0), fromReal(3.0));
		sendReq(fromReal(0.0), mkFp(1'b1, 11'h7ff, 52'h0));
		drainResults();
	endtask

	task testRange();
		sendReq(fromReal(1.0e300), fromReal(1.0e-300));
		sendReq(fromReal(1.0e-300), fromReal(1.0e300));
		// subnormal dividend reads as zero
		sendReq(mkFp(1'b0, 11'h000, 52'h8_0000_0000_0001), fromReal(2.0));
		drainResults();
	endtask

	task testCredits();
		// both credits spent on consecutive edges, short special behind long divide
		sendReq(fromReal(7.0), fromReal(3.0));
		sendReq(fromReal(1.0), fromReal(0.0));
		sendReq(fromReal(10.0), fromReal(7.0));
		sendReq(mkFp(1'b0, 11'h7ff, 52'h0), fromReal(2.0));
		drainResults();
	endtask

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin
		int maxReq;
		// exact, random, special, range and credit requests
		maxReq = 5 + 64 + 11 + 3 + 4;
		#(maxReq * (fpDivPkg::QUOT_W + 12) * 4 + 2000);
		stopRun("watchdog expired before all results came back");
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		reqValid = 1'b0;
		req = '0;
		sentCount = 0;
		reqSeen = 0;
		returnCount = 0;
		nextTag = '0;
		lfsr = 32'd85374;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		testExact();
		testRandom();
		testSpecial();
		testRange();
		testCredits();
		repeat (4) @(posedge clk);
		if (returnCount != sentCount || reqSeen != sentCount) begin
			stopRun($sformatf("credits not all back: sent %0d, seen %0d, returned %0d",
				sentCount, reqSeen, returnCount));
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/fpDivPkg.sv
hw/fpDecompose.sv
hw/mantDivider.sv
hw/fpDivCore.sv
hw/fpNormRound.sv
hw/divReqQueue.sv
hw/fpDivUnit.sv
sim/tbFpDivUnit.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, exit status tells pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing -f vlog.f --top-module tbFpDivUnit -o simTbFpDivUnit &&
./obj_dir/simTbFpDivUnit || exit 1
